// File: src/fp_fmt_pkg.sv
// Only FP32 and FP16 are known here. FP16 values sit in the low half of a
// word, or side by side as a pair when the operation is vectorial.
package fp_fmt_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int unsigned WIDTH      = 32;  // Datapath width
  localparam int unsigned FP16_WIDTH = 16;

  localparam int unsigned FP32_MAN_BITS = 23;
  localparam int unsigned FP16_MAN_BITS = 10;

  // Format code, one bit is enough for two formats
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_fmt_e;

  // ----------------------------------------
  // Special values
  // ----------------------------------------
  // Magnitude of infinity, sign bit dropped. Anything above it is a NaN
  localparam logic [WIDTH-2:0]      INF32_MAG = 31'h7f80_0000;
  localparam logic [FP16_WIDTH-2:0] INF16_MAG = 15'h7c00;

  // Canonical quiet NaNs
  localparam logic [WIDTH-1:0]      QNAN32 = 32'h7fc0_0000;
  localparam logic [FP16_WIDTH-1:0] QNAN16 = 16'h7e00;

  // ----------------------------------------
  // Operand word
  // ----------------------------------------
  // One 32-bit word read either as a single FP32 value or as two FP16
  // values. Lane 1 owns the upper half
  typedef union packed {
    logic [WIDTH-1:0]           single;
    logic [1:0][FP16_WIDTH-1:0] pair;
  } fp_word_u;

endpackage

// File: src/nc_op_pkg.sv
// Non-computational operations only. Of the status flags, these operations
// can raise nothing but NV.
package nc_op_pkg;

  // Operation codes
  typedef enum logic [2:0] {
    SGNJ  = 3'd0,  // Sign of b
    SGNJN = 3'd1,  // Inverted sign of b
    SGNJX = 3'd2,  // Sign of a XOR sign of b
    MIN   = 3'd3,
    MAX   = 3'd4
  } nc_op_e;

  // ----------------------------------------
  // Status flags
  // ----------------------------------------
  // Layout from the top bit down: NV DZ OF UF NX
  localparam int unsigned STATUS_BITS = 5;

  // Invalid operation
  localparam int unsigned NV_BIT = 4;

endpackage

// File: src/noncomp_lane.sv
// One SIMD lane with a single register stage. Without EnableFp32 the lane
// only handles FP16 in the low 16 bits and ignores the upper operand bits.
`timescale 1ns/1ps

module noncomp_lane #(
  parameter bit EnableFp32 = 1'b1
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                valid_i,
  input  nc_op_pkg::nc_op_e                   op_i,
  input  fp_fmt_pkg::fp_fmt_e                 fmt_i,
  input  logic                                vector_i,
  input  logic [fp_fmt_pkg::WIDTH-1:0]        operand_a_i,
  input  logic [fp_fmt_pkg::WIDTH-1:0]        operand_b_i,
  output logic                                valid_o,
  output logic [fp_fmt_pkg::WIDTH-1:0]        result_o,
  output logic [nc_op_pkg::STATUS_BITS-1:0]   status_o,
  output fp_fmt_pkg::fp_fmt_e                 fmt_o,
  output logic                                vector_o
);

  import fp_fmt_pkg::*;
  import nc_op_pkg::*;

  logic                   is_fp16;
  logic                   sign_a, sign_b, sign_new;
  logic [WIDTH-2:0]       mag_a, mag_b;
  logic [WIDTH-2:0]       inf_mag;
  logic                   quiet_a, quiet_b;
  logic                   nan_a, nan_b;
  logic                   snan_a, snan_b;
  logic                   a_lt_b, pick_a;
  logic [WIDTH-1:0]       selected;
  logic [WIDTH-1:0]       result_d, result_q;
  logic [STATUS_BITS-1:0] status_d, status_q;
  logic                   valid_q;
  fp_fmt_e                fmt_q;
  logic                   vector_q;

  // Lane 1 is built without FP32, so the FP32 paths fold away there
  assign is_fp16 = !EnableFp32 || (fmt_i == FP16);

  // ----------------------------------------
  // Operand classification
  // ----------------------------------------
  always_comb begin
    if (is_fp16) begin
      sign_a  = operand_a_i[FP16_WIDTH-1];
      sign_b  = operand_b_i[FP16_WIDTH-1];
      mag_a   = (WIDTH-1)'(operand_a_i[FP16_WIDTH-2:0]);
      mag_b   = (WIDTH-1)'(operand_b_i[FP16_WIDTH-2:0]);
      inf_mag = (WIDTH-1)'(INF16_MAG);
      quiet_a = operand_a_i[FP16_MAN_BITS-1];
      quiet_b = operand_b_i[FP16_MAN_BITS-1];
    end else begin
      sign_a  = operand_a_i[WIDTH-1];
      sign_b  = operand_b_i[WIDTH-1];
      mag_a   = operand_a_i[WIDTH-2:0];
      mag_b   = operand_b_i[WIDTH-2:0];
      inf_mag = INF32_MAG;
      quiet_a = operand_a_i[FP32_MAN_BITS-1];
      quiet_b = operand_b_i[FP32_MAN_BITS-1];
    end
  end

  assign nan_a  = mag_a > inf_mag;
  assign nan_b  = mag_b > inf_mag;
  assign snan_a = nan_a & ~quiet_a;  // MSB of mantissa clear
  assign snan_b = nan_b & ~quiet_b;

  // Total order on non-NaN values, -0 sorts below +0
  always_comb begin
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = mag_a > mag_b;  // Both negative
    end else begin
      a_lt_b = mag_a < mag_b;
    end
  end

  // ----------------------------------------
  // Operation
  // ----------------------------------------
  always_comb begin
    result_d = '0;
    status_d = '0;
    sign_new = sign_b;
    pick_a   = 1'b0;
    selected = operand_b_i;
    case (op_i)
      SGNJ, SGNJN, SGNJX: begin
        if (op_i == SGNJN) begin
          sign_new = ~sign_b;
        end else if (op_i == SGNJX) begin
          sign_new = sign_a ^ sign_b;
        end
        if (is_fp16) begin
          result_d = WIDTH'({sign_new, mag_a[FP16_WIDTH-2:0]});
        end else begin
          result_d = {sign_new, mag_a};
        end
      end
      MIN, MAX: begin
        status_d[NV_BIT] = snan_a | snan_b;
        if (nan_a && nan_b) begin
          pick_a = 1'b0;
        end else if (nan_a || nan_b) begin
          pick_a = nan_b;  // Take the non-NaN one
        end else begin
          pick_a = (op_i == MIN) ? a_lt_b : ~a_lt_b;
        end
        selected = pick_a ? operand_a_i : operand_b_i;
        if (nan_a && nan_b) begin
          result_d = is_fp16 ? WIDTH'(QNAN16) : QNAN32;
        end else if (is_fp16) begin
          result_d = WIDTH'(selected[FP16_WIDTH-1:0]);
        end else begin
          result_d = selected;
        end
      end
      default: result_d = '0;
    endcase
  end

  // ----------------------------------------
  // Output register
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q  <= 1'b0;
      status_q <= '0;
    end else begin
      valid_q <= valid_i;
      if (valid_i) begin
        status_q <= status_d;
      end
    end
  end

  // Payload and aux data only move with a strobe
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_q <= result_d;
      fmt_q    <= fmt_i;
      vector_q <= vector_i;
    end
  end

  assign valid_o  = valid_q;
  assign result_o = result_q;
  assign status_o = status_q;
  assign fmt_o    = fmt_q;
  assign vector_o = vector_q;

endmodule

// File: src/lane_packer.sv
// Purely combinational. Format and vector mode must come from lane 0,
// lane 1 results are only taken for vectorial FP16 operations.
`timescale 1ns/1ps

module lane_packer (
  input  logic                                lane0_valid_i,
  input  logic                                lane1_valid_i,
  input  logic [fp_fmt_pkg::WIDTH-1:0]        lane0_result_i,
  input  logic [fp_fmt_pkg::WIDTH-1:0]        lane1_result_i,
  input  logic [nc_op_pkg::STATUS_BITS-1:0]   lane0_status_i,
  input  logic [nc_op_pkg::STATUS_BITS-1:0]   lane1_status_i,
  input  fp_fmt_pkg::fp_fmt_e                 fmt_i,
  input  logic                                vector_i,
  output logic                                valid_o,
  output logic [fp_fmt_pkg::WIDTH-1:0]        result_o,
  output logic [nc_op_pkg::STATUS_BITS-1:0]   status_o
);

  import fp_fmt_pkg::*;
  import nc_op_pkg::*;

  fp_word_u lane0_word, lane1_word;
  fp_word_u packed_word;

  assign lane0_word = lane0_result_i;
  assign lane1_word = lane1_result_i;

  // ----------------------------------------
  // Result assembly
  // ----------------------------------------
  always_comb begin
    if (fmt_i == FP32) begin
      packed_word.single = lane0_word.single;
    end else begin
      packed_word.pair[0] = lane0_word.pair[0];
      // Upper half is lane 1 for vectors, NaN box otherwise
      if (vector_i) begin
        packed_word.pair[1] = lane1_word.pair[0];
      end else begin
        packed_word.pair[1] = '1;
      end
    end
  end

  assign result_o = packed_word.single;

  // Idle lanes keep stale flags in their registers, so mask by valid
  assign status_o = ({STATUS_BITS{lane0_valid_i}} & lane0_status_i)
                  | ({STATUS_BITS{lane1_valid_i}} & lane1_status_i);

  assign valid_o = lane0_valid_i;  // Lane 0 runs for every operation

endmodule

// File: src/noncomp_slice.sv
// Two-lane sign-injection and min/max unit with a fixed latency of one cycle.
// Every in_valid_i strobe is accepted, there is no back-pressure.
`timescale 1ns/1ps

module noncomp_slice #(
  parameter bit EnableVectors = 1'b1
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                in_valid_i,
  input  nc_op_pkg::nc_op_e                   op_i,
  input  fp_fmt_pkg::fp_fmt_e                 fmt_i,
  input  logic                                vectorial_op_i,
  input  logic [fp_fmt_pkg::WIDTH-1:0]        operand_a_i,
  input  logic [fp_fmt_pkg::WIDTH-1:0]        operand_b_i,
  output logic                                out_valid_o,
  output logic [fp_fmt_pkg::WIDTH-1:0]        result_o,
  output logic [nc_op_pkg::STATUS_BITS-1:0]   status_o
);

  import fp_fmt_pkg::*;
  import nc_op_pkg::*;

  logic                   vector_mode;
  logic                   lane1_valid_in;
  fp_word_u               opa_word, opb_word;
  logic [WIDTH-1:0]       lane1_opa, lane1_opb;

  logic                   lane0_valid, lane1_valid;
  logic [WIDTH-1:0]       lane0_result, lane1_result;
  logic [STATUS_BITS-1:0] lane0_status, lane1_status;
  fp_fmt_e                res_fmt;
  logic                   res_vector;

  // ----------------------------------------
  // Input side
  // ----------------------------------------
  assign vector_mode    = EnableVectors && (fmt_i == FP16) && vectorial_op_i;
  assign lane1_valid_in = in_valid_i & vector_mode;  // Upper lane only for vectors

  assign opa_word  = operand_a_i;
  assign opb_word  = operand_b_i;
  assign lane1_opa = {{FP16_WIDTH{1'b0}}, opa_word.pair[1]};
  assign lane1_opb = {{FP16_WIDTH{1'b0}}, opb_word.pair[1]};

  // ----------------------------------------
  // Lanes
  // ----------------------------------------
  noncomp_lane #(
    .EnableFp32 ( 1'b1 )
  ) i_lane0 (
    .clk_i       ( clk_i           ),
    .reset_i     ( reset_i         ),
    .valid_i     ( in_valid_i      ),
    .op_i        ( op_i            ),
    .fmt_i       ( fmt_i           ),
    .vector_i    ( vector_mode     ),
    .operand_a_i ( opa_word.single ),
    .operand_b_i ( opb_word.single ),
    .valid_o     ( lane0_valid     ),
    .result_o    ( lane0_result    ),
    .status_o    ( lane0_status    ),
    .fmt_o       ( res_fmt         ),  // Aux data rides with lane 0
    .vector_o    ( res_vector      )
  );

  noncomp_lane #(
    .EnableFp32 ( 1'b0 )
  ) i_lane1 (
    .clk_i       ( clk_i          ),
    .reset_i     ( reset_i        ),
    .valid_i     ( lane1_valid_in ),
    .op_i        ( op_i           ),
    .fmt_i       ( fmt_i          ),
    .vector_i    ( vector_mode    ),
    .operand_a_i ( lane1_opa      ),
    .operand_b_i ( lane1_opb      ),
    .valid_o     ( lane1_valid    ),
    .result_o    ( lane1_result   ),
    .status_o    ( lane1_status   ),
    .fmt_o       (                ),
    .vector_o    (                )
  );

  // Output side
  lane_packer i_packer (
    .lane0_valid_i  ( lane0_valid  ),
    .lane1_valid_i  ( lane1_valid  ),
    .lane0_result_i ( lane0_result ),
    .lane1_result_i ( lane1_result ),
    .lane0_status_i ( lane0_status ),
    .lane1_status_i ( lane1_status ),
    .fmt_i          ( res_fmt      ),
    .vector_i       ( res_vector   ),
    .valid_o        ( out_valid_o  ),
    .result_o       ( result_o     ),
    .status_o       ( status_o     )
  );

endmodule

// File: sim/slice_chk.sv
// Timing rules of the slice as concurrent assertions, bound into noncomp_slice.
// Assumes a single register stage between strobe and result.
`timescale 1ns/1ps

module slice_chk (
  input logic                         clk_i,
  input logic                         reset_i,
  input logic                         in_valid_i,
  input logic                         out_valid_i,
  input logic [fp_fmt_pkg::WIDTH-1:0] result_i
);

  a_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    in_valid_i |=> out_valid_i)
    else $error("out_valid_o missing one cycle after a strobe");

  a_no_spurious: assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_i |-> $past(in_valid_i))
    else $error("out_valid_o high without a strobe one cycle earlier");

  // Synchronous reset clears the valid bits at the edge
  a_reset_low: assert property (@(posedge clk_i) reset_i |=> !out_valid_i)
    else $error("out_valid_o high while reset is applied");

  a_known: assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_i |-> !$isunknown(result_i))
    else $error("result_o has unknown bits while out_valid_o is high");

endmodule

// File: sim/slice_monitor.sv
// Watches the slice ports and checks each result one cycle after its strobe.
// EnableVectors has to match the DUT setting.
`timescale 1ns/1ps

module slice_monitor #(
  parameter bit EnableVectors = 1'b1
) (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              in_valid_i,
  input  nc_op_pkg::nc_op_e                 op_i,
  input  fp_fmt_pkg::fp_fmt_e               fmt_i,
  input  logic                              vectorial_op_i,
  input  logic [fp_fmt_pkg::WIDTH-1:0]      operand_a_i,
  input  logic [fp_fmt_pkg::WIDTH-1:0]      operand_b_i,
  input  logic                              out_valid_i,
  input  logic [fp_fmt_pkg::WIDTH-1:0]      result_i,
  input  logic [nc_op_pkg::STATUS_BITS-1:0] status_i,
  output int unsigned                       error_count_o
);

  import fp_fmt_pkg::*;
  import nc_op_pkg::*;

  logic                   pending = 1'b0;
  logic [WIDTH-1:0]       exp_result, rec_a, rec_b;
  logic [STATUS_BITS-1:0] exp_status;
  nc_op_e                 rec_op;
  int unsigned            errors = 0;

  assign error_count_o = errors;

  // Returns {nv, result}, FP16 works on the low half only
  function automatic logic [WIDTH:0] ref_lane(input nc_op_e op,
                                               input logic [WIDTH-1:0] a_in, b_in,
                                               input logic half);
    logic [WIDTH-1:0] mask, sgn, exp_ones, qbit, man, a, b, key_a, key_b, res;
    logic             nan_a, nan_b, nv;
    mask     = half ? 32'h0000_ffff : 32'hffff_ffff;
    sgn      = half ? 32'h0000_8000 : 32'h8000_0000;
    exp_ones = half ? 32'h0000_7c00 : 32'h7f80_0000;
    qbit     = half ? 32'h0000_0200 : 32'h0040_0000;  // Quiet bit, mantissa MSB
    man      = (qbit << 1) - 1;
    a        = a_in & mask;
    b        = b_in & mask;
    nan_a    = ((a & exp_ones) == exp_ones) && ((a & man) != 0);
    nan_b    = ((b & exp_ones) == exp_ones) && ((b & man) != 0);
    nv       = (nan_a && (a & qbit) == 0) || (nan_b && (b & qbit) == 0);
    // Unsigned key that sorts like the real line, -0 below +0
    key_a    = ((a & sgn) != 0) ? (~a & mask) : (a | sgn);
    key_b    = ((b & sgn) != 0) ? (~b & mask) : (b | sgn);
    case (op)
      SGNJ:    res = (a & ~sgn) | (b & sgn);
      SGNJN:   res = (a & ~sgn) | (~b & sgn);
      SGNJX:   res = a ^ (b & sgn);
      default: begin
        if (nan_a && nan_b) res = half ? WIDTH'(QNAN16) : QNAN32;
        else if (nan_a) res = b;
        else if (nan_b) res = a;
        else if (op == MIN) res = (key_a < key_b) ? a : b;
        else res = (key_a > key_b) ? a : b;
      end
    endcase
    return {nv & (op == MIN || op == MAX), res};
  endfunction

  // Whole word as the slice should present it, {status, result}
  function automatic logic [STATUS_BITS+WIDTH-1:0] ref_word(input nc_op_e op,
                                                            input fp_fmt_e fmt,
                                                            input logic vec,
                                                            input logic [WIDTH-1:0] a, b);
    logic [WIDTH:0]         lo, hi;
    logic [WIDTH-1:0]       res;
    logic [STATUS_BITS-1:0] st;
    st = '0;
    if (fmt == FP32) begin
      lo         = ref_lane(op, a, b, 1'b0);
      res        = lo[WIDTH-1:0];
      st[NV_BIT] = lo[WIDTH];
    end else if (EnableVectors && vec) begin
      lo         = ref_lane(op, a, b, 1'b1);
      hi         = ref_lane(op, a >> FP16_WIDTH, b >> FP16_WIDTH, 1'b1);
      res        = {hi[FP16_WIDTH-1:0], lo[FP16_WIDTH-1:0]};
      st[NV_BIT] = lo[WIDTH] | hi[WIDTH];
    end else begin
      lo         = ref_lane(op, a, b, 1'b1);
      res        = {16'hffff, lo[FP16_WIDTH-1:0]};  // NaN box
      st[NV_BIT] = lo[WIDTH];
    end
    return {st, res};
  endfunction

  // ----------------------------------------
  // Compare at the falling edge, where inputs and outputs are settled
  always @(negedge clk_i) begin
    if (reset_i) begin
      if (out_valid_i !== 1'b0) begin
        $display("out_valid_o is not low during reset");
        errors++;
      end
      pending = 1'b0;
    end else begin
      if (pending) begin
        if (out_valid_i !== 1'b1) begin
          $display("out_valid_o did not pulse one cycle after a %s strobe", rec_op.name());
          errors++;
        end else begin
          if (result_i !== exp_result) begin
            $display("mismatch result_o: got %h, expected %h (%s a=%h b=%h)",
                     result_i, exp_result, rec_op.name(), rec_a, rec_b);
            errors++;
          end
          if (status_i !== exp_status) begin
            $display("mismatch status_o: got %h, expected %h (%s a=%h b=%h)",
                     status_i, exp_status, rec_op.name(), rec_a, rec_b);
            errors++;
          end
        end
      end else if (out_valid_i !== 1'b0) begin
        $display("out_valid_o pulsed with no strobe in the cycle before");
        errors++;
      end
      pending = in_valid_i;
      if (in_valid_i) begin
        {exp_status, exp_result} = ref_word(op_i, fmt_i, vectorial_op_i,
                                            operand_a_i, operand_b_i);
        rec_op = op_i;
        rec_a  = operand_a_i;
        rec_b  = operand_b_i;
      end
    end
  end

endmodule

// File: sim/noncomp_slice_tb.sv
// Random and special-value stimulus for the slice, driven from an LFSR.
// Checking lives in slice_monitor, the run stops at a cycle limit.
`timescale 1ns/1ps

module noncomp_slice_tb;

  import fp_fmt_pkg::*;
  import nc_op_pkg::*;

  localparam bit          EnableVectors  = 1'b1;
  localparam int unsigned N_SGNJ         = 60;
  localparam int unsigned N_SCALAR       = 60;
  localparam int unsigned N_VECTOR       = 80;
  localparam int unsigned N_SPECIAL      = 80;
  localparam int unsigned N_GAPS         = 60;
  localparam int unsigned TOTAL_OPS      = N_SGNJ + N_SCALAR + N_VECTOR + N_SPECIAL + N_GAPS;
  localparam int unsigned TIMEOUT_CYCLES = 2 * TOTAL_OPS + 100;

  logic                   clk_i, reset_i, in_valid_i, vectorial_op_i;
  nc_op_e                 op_i;
  fp_fmt_e                fmt_i;
  logic [WIDTH-1:0]       operand_a_i, operand_b_i, result_o;
  logic                   out_valid_o;
  logic [STATUS_BITS-1:0] status_o;
  int unsigned            error_count, op_count, cycle_count;
  logic [31:0]            lfsr_state;

  noncomp_slice #(.EnableVectors(EnableVectors)) i_dut (.*);

  slice_monitor #(.EnableVectors(EnableVectors)) i_mon (
    .clk_i, .reset_i, .in_valid_i, .op_i, .fmt_i, .vectorial_op_i,
    .operand_a_i, .operand_b_i,
    .out_valid_i   ( out_valid_o ),
    .result_i      ( result_o    ),
    .status_i      ( status_o    ),
    .error_count_o ( error_count )
  );

  bind noncomp_slice slice_chk i_chk (
    .clk_i, .reset_i, .in_valid_i,
    .out_valid_i ( out_valid_o ),
    .result_i    ( result_o    )
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;  // 8 ns period

  // ----------------------------------------
  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      value      = {value[30:0], fb};
    end
    return value;
  endfunction

  function automatic logic [FP16_WIDTH-1:0] rand_fp16(input logic specials);
    logic [2:0] sel;
    logic       sign;
    sel  = specials ? 3'(rand_bits(3)) : 3'd0;
    sign = 1'(rand_bits(1));
    case (sel)
      3'd3:    return {sign, 5'h1f, 1'b1, 9'(rand_bits(9))};         // Quiet NaN
      3'd4:    return {sign, 5'h1f, 1'b0, 8'(rand_bits(8)), 1'b1};  // Signaling NaN
      3'd5:    return 16'h0000;
      3'd6:    return 16'h8000;
      3'd7:    return {sign, 15'h7c00};                              // Infinity
      default: return 16'(rand_bits(16));
    endcase
  endfunction

  function automatic logic [WIDTH-1:0] rand_fp32(input logic specials);
    logic [2:0] sel;
    logic       sign;
    sel  = specials ? 3'(rand_bits(3)) : 3'd0;
    sign = 1'(rand_bits(1));
    case (sel)
      3'd3:    return {sign, 8'hff, 1'b1, 22'(rand_bits(22))};
      3'd4:    return {sign, 8'hff, 1'b0, 21'(rand_bits(21)), 1'b1};
      3'd5:    return 32'h0000_0000;
      3'd6:    return 32'h8000_0000;
      3'd7:    return {sign, 31'h7f80_0000};
      default: return rand_bits(32);
    endcase
  endfunction

  function automatic logic [WIDTH-1:0] make_word(input fp_fmt_e fmt, input logic vec,
                                                 input logic specials);
    logic [FP16_WIDTH-1:0] hi, lo;
    if (fmt == FP32) begin
      return rand_fp32(specials);
    end
    lo = rand_fp16(specials);
    hi = vec ? rand_fp16(specials) : FP16_WIDTH'(rand_bits(16));  // Junk for scalars
    return {hi, lo};
  endfunction

  // Kind 1 idle, 2 FP32 sign injection, 3 FP16 scalar, 4 vector, 5 min/max, 6 gaps
  task automatic run_test(input int unsigned kind, input string name,
                          input int unsigned n);
    int unsigned base;
    nc_op_e      op;
    fp_fmt_e     fmt;
    logic        vec;
    base = error_count;
    for (int unsigned i = 0; i < n; i++) begin
      fmt = (kind == 2) ? FP32 : (kind == 3) ? FP16 : fp_fmt_e'(1'(rand_bits(1)));
      vec = (kind == 3) ? 1'b0 : (kind == 4) ? 1'b1 : 1'(rand_bits(1));
      case (kind)
        2:       op = nc_op_e'(3'(rand_bits(2) % 3));
        5:       op = rand_bits(1) != 0 ? MIN : MAX;
        default: op = nc_op_e'(3'(rand_bits(3) % 5));
      endcase
      @(posedge clk_i);
      in_valid_i     <= 1'b1;
      op_i           <= op;
      fmt_i          <= fmt;
      vectorial_op_i <= vec;
      operand_a_i    <= make_word(fmt, vec, kind != 2);
      operand_b_i    <= make_word(fmt, vec, kind != 2);
      op_count++;
      if (kind == 6 && rand_bits(1) != 0) begin
        @(posedge clk_i);
        in_valid_i <= 1'b0;
      end
    end
    @(posedge clk_i);
    in_valid_i <= 1'b0;
    repeat (2) @(posedge clk_i);  // Latency is one cycle, last result is checked by now
    $display("test %0d, %s: %0d ops, %0d errors", kind, name, n, error_count - base);
  endtask

  // ----------------------------------------
  initial begin : main_seq
    lfsr_state     = 32'h17d37f8a;
    op_count       = 0;
    reset_i        = 1'b1;
    in_valid_i     = 1'b0;
    op_i           = SGNJ;
    fmt_i          = FP32;
    vectorial_op_i = 1'b0;
    operand_a_i    = '0;
    operand_b_i    = '0;
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    run_test(1, "reset and idle", 0);
    run_test(2, "fp32 sign injection", N_SGNJ);
    run_test(3, "fp16 scalar nan box", N_SCALAR);
    run_test(4, "vector lanes", N_VECTOR);
    run_test(5, "min/max special values", N_SPECIAL);
    run_test(6, "strobes with gaps", N_GAPS);
    $display("summary: 6 tests, %0d ops, %0d errors", op_count, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: build.f
src/fp_fmt_pkg.sv
src/nc_op_pkg.sv
src/noncomp_lane.sv
src/lane_packer.sv
src/noncomp_slice.sv
sim/slice_chk.sv
sim/slice_monitor.sv
sim/noncomp_slice_tb.sv

// File: Makefile
TOP := noncomp_slice_tb

.PHONY: help test clean

help:
	@echo "make test   build and run the simulation with Verilator"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
